// File: Makefile
# Verilator build for the l2 data bank testbench

TOOL     = verilator
FLAGS    = --binary --timing
LINT     = --lint-only --timing
TOP      = l2d_bank_tb
FILELIST = src.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "test failed" $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: design/l2d_bank.sv
// l2 data bank top
// subarray decode, wired-or read bus, linked fuse chain

`timescale 1ns/1ps

module l2d_bank #(
   parameter int NUM_SUB   = 2,
   parameter int SUB_SET_W = 6
) (
   input  logic                                   rclk,
   input  logic                                   arst_l,
   input  logic                                   acc,           // access strobe
   input  logic                                   wr_en,
   input  logic [l2d_pkg::NUM_WAYS-1:0]           way_sel,
   input  logic [SUB_SET_W+$clog2(NUM_SUB)-1:0]   set,           // upper bits pick subarray
   input  logic [l2d_pkg::NUM_WORDS-1:0]          word_en,
   input  logic [l2d_pkg::LINE_W-1:0]             wr_data,
   input  logic                                   mem_write_disable,
   input  logic                                   fuse_wren,
   input  logic                                   fuse_rden,
   input  logic [l2d_pkg::RID_W-1:0]              fuse_rid,
   input  logic                                   fuse_data_in,
   input  logic                                   fuse_read_data_in,
   output logic [l2d_pkg::LINE_W-1:0]             rd_data,
   output logic                                   fuse_data_out
);

   import l2d_pkg::*;

   localparam int SEL_W = $clog2(NUM_SUB);
   localparam int SET_W = SUB_SET_W + SEL_W;

   logic [NUM_SUB-1:0] col_sel;              // per subarray access strobe
   logic [LINE_W-1:0]  rd_bus [NUM_SUB];     // per subarray read bus
   logic [NUM_SUB:0]   fuse_chain;           // serial links between subarrays

   // chain enters subarray 0, leaves the last one
   assign fuse_chain[0] = fuse_read_data_in;
   assign fuse_data_out = fuse_chain[NUM_SUB];

   ///////////////////////////////////////////////////////////////////////
   // subarrays
   ///////////////////////////////////////////////////////////////////////

   for (genvar s = 0; s < NUM_SUB; s++) begin : g_sub
      // steer acc by upper set bits
      assign col_sel[s] = acc & ((set >> SUB_SET_W) == SET_W'(s));

      l2d_subarray #(
         .SUB_SET_W (SUB_SET_W)
      ) u_sub (
         .rclk              (rclk),
         .arst_l            (arst_l),
         .col_sel           (col_sel[s]),
         .wr_en             (wr_en),
         .way_sel           (way_sel),
         .set               (set[SUB_SET_W-1:0]),
         .word_en           (word_en),
         .wr_data           (wr_data),
         .mem_write_disable (mem_write_disable),
         .fuse_wren         (fuse_wren),           // fuse load is broadcast
         .fuse_rden         (fuse_rden),
         .fuse_rid          (fuse_rid),
         .fuse_data_in      (fuse_data_in),
         .fuse_chain_in     (fuse_chain[s]),
         .rd_out            (rd_bus[s]),
         .fuse_chain_out    (fuse_chain[s+1])
      );
   end

   ///////////////////////////////////////////////////////////////////////
   // wired-or read bus
   ///////////////////////////////////////////////////////////////////////

   // idle subarrays drive zero, no flops at this level
   always_comb begin
      rd_data = '0;
      for (int s = 0; s < NUM_SUB; s++) begin
         rd_data = rd_data | rd_bus[s];
      end
   end

endmodule

// File: design/l2d_pkg.sv
// l2 data bank shared constants
// line and word geometry, redundancy register ids and chain order

package l2d_pkg;

   // data line geometry
   localparam int WORD_W    = 39;                  // one ecc protected word
   localparam int NUM_WORDS = 4;                   // words per line
   localparam int LINE_W    = WORD_W * NUM_WORDS;  // 156 bit line
   localparam int NUM_WAYS  = 2;                   // ways per subarray

   ///////////////////////////////////////////////////////////////////////
   // redundancy registers
   ///////////////////////////////////////////////////////////////////////

   localparam int RED_W   = 9;    // bits per redundancy register
   localparam int NUM_RED = 6;    // registers per subarray
   localparam int RID_W   = 3;    // register id width

   // register ids, codes 6 and 7 select nothing
   typedef enum logic [RID_W-1:0] {
      RID_TOP_COL  = 3'd0,
      RID_TOP_EVEN = 3'd1,
      RID_BOT_COL  = 3'd2,
      RID_BOT_EVEN = 3'd3,
      RID_TOP_ODD  = 3'd4,
      RID_BOT_ODD  = 3'd5
   } red_rid_t;

   // chain position to id, position 0 is fed first
   localparam red_rid_t RED_ORDER [NUM_RED] = '{
      RID_BOT_ODD, RID_BOT_EVEN, RID_BOT_COL,
      RID_TOP_ODD, RID_TOP_EVEN, RID_TOP_COL
   };

endpackage

// File: design/l2d_red_chain.sv
// redundancy registers of one subarray
// six 9 bit shift registers, selective fuse load and serial chain readout

`timescale 1ns/1ps

module l2d_red_chain (
   input  logic                      rclk,
   input  logic                      arst_l,
   input  logic                      fuse_wren,     // load one register
   input  logic                      fuse_rden,     // shift the whole chain
   input  logic [l2d_pkg::RID_W-1:0] fuse_rid,
   input  logic                      fuse_data_in,  // load data bit
   input  logic                      chain_in,      // serial in from previous stage
   output logic                      chain_out      // msb of top column reg
);

   import l2d_pkg::*;

   // red_reg[0] is bottom odd row, red_reg[NUM_RED-1] is top column
   logic [RED_W-1:0] red_reg [NUM_RED];

   ///////////////////////////////////////////////////////////////////////
   // load and shift
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         for (int i = 0; i < NUM_RED; i++) begin
            red_reg[i] <= '0;
         end
      end
      else if (fuse_wren) begin
         // wren wins over rden
         for (int i = 0; i < NUM_RED; i++) begin
            if (fuse_rid == RED_ORDER[i]) begin
               red_reg[i] <= {red_reg[i][RED_W-2:0], fuse_data_in};  // shift in lsb
            end
         end
      end
      else if (fuse_rden) begin
         // one 54 bit chain, bottom odd row first
         red_reg[0] <= {red_reg[0][RED_W-2:0], chain_in};
         for (int i = 1; i < NUM_RED; i++) begin
            red_reg[i] <= {red_reg[i][RED_W-2:0], red_reg[i-1][RED_W-1]};
         end
      end
   end

   // serial out to next subarray or bank pin
   assign chain_out = red_reg[NUM_RED-1][RED_W-1];

endmodule

// File: design/l2d_subarray.sv
// two way l2 data subarray
// input flops, access blocking, word merge write, two cycle read hold, wired-or out

`timescale 1ns/1ps

module l2d_subarray #(
   parameter int SUB_SET_W = 6
) (
   input  logic                          rclk,
   input  logic                          arst_l,
   input  logic                          col_sel,            // access strobe, this subarray
   input  logic                          wr_en,              // 1 write, 0 read
   input  logic [l2d_pkg::NUM_WAYS-1:0]  way_sel,            // one hot way
   input  logic [SUB_SET_W-1:0]          set,
   input  logic [l2d_pkg::NUM_WORDS-1:0] word_en,
   input  logic [l2d_pkg::LINE_W-1:0]    wr_data,
   input  logic                          mem_write_disable,  // blocks every access
   input  logic                          fuse_wren,
   input  logic                          fuse_rden,
   input  logic [l2d_pkg::RID_W-1:0]     fuse_rid,
   input  logic                          fuse_data_in,
   input  logic                          fuse_chain_in,
   output logic [l2d_pkg::LINE_W-1:0]    rd_out,             // zero when idle
   output logic                          fuse_chain_out
);

   import l2d_pkg::*;

   localparam int NUM_SETS = 2 ** SUB_SET_W;

   logic                 acc_ok;       // request accepted at this edge
   logic                 acc_d1;       // accepted last edge, also blocks next one
   logic [NUM_WAYS-1:0]  way_sel_d1;
   logic [SUB_SET_W-1:0] set_d1;
   logic [NUM_WORDS-1:0] word_en_d1;
   logic                 wr_en_d1;
   logic [LINE_W-1:0]    wr_data_d1;
   logic [LINE_W-1:0]    wr_mask;      // word_en spread to bits
   logic                 wr_go;
   logic [LINE_W-1:0]    way_rd [NUM_WAYS];
   logic [LINE_W-1:0]    rd_q;         // read line, held two cycles
   logic                 rd_vld;       // first read data cycle
   logic                 rd_keep;      // second read data cycle

   ///////////////////////////////////////////////////////////////////////
   // request capture and blocking
   ///////////////////////////////////////////////////////////////////////

   // no access right after an accepted one, none while disabled
   assign acc_ok = col_sel & (|way_sel) & ~mem_write_disable & ~acc_d1;

   always_ff @(posedge rclk) begin
      if (!arst_l) begin
         acc_d1  <= 1'b0;
         rd_vld  <= 1'b0;
         rd_keep <= 1'b0;
      end
      else begin
         acc_d1  <= acc_ok;
         rd_vld  <= acc_d1 & ~wr_en_d1;   // read performed this edge
         rd_keep <= rd_vld;               // hold for one more cycle
      end
   end

   // request payload, sampled every cycle
   always_ff @(posedge rclk) begin
      way_sel_d1 <= way_sel;
      set_d1     <= set;
      word_en_d1 <= word_en;
      wr_en_d1   <= wr_en;
      wr_data_d1 <= wr_data;
   end

   ///////////////////////////////////////////////////////////////////////
   // way arrays
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < NUM_WORDS; i++) begin
         wr_mask[i*WORD_W +: WORD_W] = {WORD_W{word_en_d1[i]}};
      end
   end

   assign wr_go = acc_d1 & wr_en_d1;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      logic [LINE_W-1:0] mem [NUM_SETS];   // array contents not reset

      assign way_rd[w] = mem[set_d1];

      // merge new words over old line per word enable
      always_ff @(posedge rclk) begin
         if (wr_go && way_sel_d1[w]) begin
            mem[set_d1] <= (wr_data_d1 & wr_mask) | (way_rd[w] & ~wr_mask);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // read path
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (acc_d1 && !wr_en_d1) begin
         rd_q <= way_sel_d1[0] ? way_rd[0] : way_rd[1];   // way 0 has priority
      end
   end

   // zero unless presenting, so the bank can or the buses
   assign rd_out = (rd_vld | rd_keep) ? rd_q : '0;

   // redundancy registers
   l2d_red_chain u_red_chain (
      .rclk         (rclk),
      .arst_l       (arst_l),
      .fuse_wren    (fuse_wren),
      .fuse_rden    (fuse_rden),
      .fuse_rid     (fuse_rid),
      .fuse_data_in (fuse_data_in),
      .chain_in     (fuse_chain_in),
      .chain_out    (fuse_chain_out)
   );

endmodule

// File: src.f
design/l2d_pkg.sv
design/l2d_red_chain.sv
design/l2d_subarray.sv
design/l2d_bank.sv
verif/l2d_bank_tb.sv

// File: verif/l2d_bank_tb.sv
// testbench for the l2 data bank
// file driven stimulus, reference model of arrays and fuse chain, timeout

`timescale 1ns/1ps

module l2d_bank_tb;

   import l2d_pkg::*;

   localparam int NUM_SUB   = 2;
   localparam int SUB_SET_W = 6;
   localparam int SET_W     = SUB_SET_W + 1;
   localparam int CHAIN_W   = NUM_SUB * NUM_RED * RED_W;   // 108 bit bank chain

   logic                 rclk;
   logic                 arst_l;
   logic                 acc;
   logic                 wr_en;
   logic [NUM_WAYS-1:0]  way_sel;
   logic [SET_W-1:0]     set;
   logic [NUM_WORDS-1:0] word_en;
   logic [LINE_W-1:0]    wr_data;
   logic                 mem_write_disable;
   logic                 fuse_wren;
   logic                 fuse_rden;
   logic [RID_W-1:0]     fuse_rid;
   logic                 fuse_data_in;
   logic                 fuse_read_data_in;
   logic [LINE_W-1:0]    rd_data;
   logic                 fuse_data_out;

   // stimulus records
   logic [7:0]        op_q [$];
   logic [SET_W-1:0]  set_q [$];
   logic [1:0]        way_q [$];
   logic [3:0]        wen_q [$];
   logic [LINE_W-1:0] data_q [$];
   logic [LINE_W-1:0] exp_q [$];

   // reference model
   logic [LINE_W-1:0]  mem_m [NUM_WAYS][2**SET_W];
   logic [CHAIN_W-1:0] fuse_m;          // msb leaves the bank first
   int                 cyc_cnt = 0;
   int                 limit   = 0;     // zero until the file is read

   l2d_bank #(
      .NUM_SUB   (NUM_SUB),
      .SUB_SET_W (SUB_SET_W)
   ) UUT (
      .rclk              (rclk),
      .arst_l            (arst_l),
      .acc               (acc),
      .wr_en             (wr_en),
      .way_sel           (way_sel),
      .set               (set),
      .word_en           (word_en),
      .wr_data           (wr_data),
      .mem_write_disable (mem_write_disable),
      .fuse_wren         (fuse_wren),
      .fuse_rden         (fuse_rden),
      .fuse_rid          (fuse_rid),
      .fuse_data_in      (fuse_data_in),
      .fuse_read_data_in (fuse_read_data_in),
      .rd_data           (rd_data),
      .fuse_data_out     (fuse_data_out)
   );

   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;
   end

   ///////////////////////////////////////////////////////////////////////
   // checking helpers
   ///////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input logic [LINE_W-1:0] got,
                            input logic [LINE_W-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   // chain position of a register id, bottom odd row is fed first
   function automatic int chain_pos(input logic [RID_W-1:0] rid);
      case (rid)
         3'd5:    return 0;
         3'd3:    return 1;
         3'd2:    return 2;
         3'd4:    return 3;
         3'd1:    return 4;
         3'd0:    return 5;
         default: return -1;
      endcase
   endfunction

   task automatic drive_req(input logic we, input logic [SET_W-1:0] s, input logic [1:0] w,
                            input logic [3:0] en, input logic [LINE_W-1:0] d,
                            input logic dis);
      @(posedge rclk);
      acc               <= 1'b1;
      wr_en             <= we;
      set               <= s;
      way_sel           <= w;
      word_en           <= en;
      wr_data           <= d;
      mem_write_disable <= dis;
   endtask

   task automatic idle_bus();
      @(posedge rclk);
      acc               <= 1'b0;
      mem_write_disable <= 1'b0;
   endtask

   // two data cycles, zero around them
   task automatic watch_read(input logic [LINE_W-1:0] exp, input logic lead);
      if (lead) begin
         @(negedge rclk);
         check_val("rd_data", rd_data, '0);   // cycle before data
         @(posedge rclk);
      end
      @(negedge rclk);
      check_val("rd_data", rd_data, exp);
      @(posedge rclk);
      @(negedge rclk);
      check_val("rd_data", rd_data, exp);
      @(posedge rclk);
      @(negedge rclk);
      check_val("rd_data", rd_data, '0);
      @(posedge rclk);
      @(negedge rclk);
      check_val("rd_data", rd_data, '0);   // nothing from a dropped request
   endtask

   task automatic model_write(input logic [SET_W-1:0] s, input logic [1:0] w,
                              input logic [3:0] en, input logic [LINE_W-1:0] d);
      for (int k = 0; k < NUM_WAYS; k++) begin
         if (w[k]) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
               if (en[i]) mem_m[k][s][i*WORD_W +: WORD_W] = d[i*WORD_W +: WORD_W];
            end
         end
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // stimulus file
   ///////////////////////////////////////////////////////////////////////

   task automatic read_stim();
      int                fd;
      int                n;
      string             line;
      logic [7:0]        op;
      logic [SET_W-1:0]  s;
      logic [1:0]        w;
      logic [3:0]        en;
      logic [LINE_W-1:0] d;
      logic [LINE_W-1:0] e;
      fd = $fopen("verif/l2d_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file");
         $display("test failed");
         $fatal(1);
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") continue;   // comment or blank
         n = $sscanf(line, " %c %h %h %h %h %h", op, s, w, en, d, e);
         if (n == 6) begin
            op_q.push_back(op);
            set_q.push_back(s);
            way_q.push_back(w);
            wen_q.push_back(en);
            data_q.push_back(d);
            exp_q.push_back(e);
         end
      end
      $fclose(fd);
   endtask

   // cycle limit guard
   always @(posedge rclk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (limit != 0 && cyc_cnt >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("test failed");
         $fatal(1);
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // main sequence
   ///////////////////////////////////////////////////////////////////////

   initial begin
      int sum_shift;
      void'($urandom(32'h5b56_e8a3));
      arst_l            = 1'b0;
      acc               = 1'b0;
      wr_en             = 1'b0;
      way_sel           = '0;
      set               = '0;
      word_en           = '0;
      wr_data           = '0;
      mem_write_disable = 1'b0;
      fuse_wren         = 1'b0;
      fuse_rden         = 1'b0;
      fuse_rid          = '0;
      fuse_data_in      = 1'b0;
      fuse_read_data_in = 1'b0;
      fuse_m            = '0;
      sum_shift         = 0;

      read_stim();
      foreach (op_q[r]) begin
         if (op_q[r] == "S") begin
            sum_shift += int'(set_q[r]);
         end
      end
      limit = 16 + 40 * op_q.size() + sum_shift;

      repeat (16) @(posedge rclk);
      arst_l <= 1'b1;

      foreach (op_q[r]) begin
         case (op_q[r])
            "W", "D": begin
               drive_req(1'b1, set_q[r], way_q[r], wen_q[r], data_q[r], op_q[r] == "D");
               idle_bus();
               @(posedge rclk);   // write lands here
               if (op_q[r] == "W") model_write(set_q[r], way_q[r], wen_q[r], data_q[r]);
            end
            "R": begin
               check_val("model line", mem_m[way_q[r][0] ? 0 : 1][set_q[r]], exp_q[r]);
               drive_req(1'b0, set_q[r], way_q[r], 4'h0, '0, 1'b0);
               idle_bus();
               watch_read(exp_q[r], 1'b1);
            end
            "B": begin
               // read then a write right behind it, write is dropped
               drive_req(1'b0, set_q[r], way_q[r], 4'h0, '0, 1'b0);
               drive_req(1'b1, set_q[r], way_q[r], wen_q[r], data_q[r], 1'b0);
               idle_bus();
               watch_read(exp_q[r], 1'b0);
            end
            "F": begin
               for (int b = RED_W - 1; b >= 0; b--) begin
                  @(posedge rclk);
                  fuse_wren    <= 1'b1;
                  fuse_rid     <= set_q[r][RID_W-1:0];
                  fuse_data_in <= data_q[r][b];
                  for (int s = 0; s < NUM_SUB; s++) begin
                     fuse_m[(s*NUM_RED + chain_pos(set_q[r][RID_W-1:0]))*RED_W +: RED_W] =
                        {fuse_m[(s*NUM_RED + chain_pos(set_q[r][RID_W-1:0]))*RED_W +: RED_W-1],
                         data_q[r][b]};
                  end
               end
               @(posedge rclk);
               fuse_wren <= 1'b0;
            end
            "S": begin
               for (int i = 0; i < int'(set_q[r]); i++) begin
                  @(posedge rclk);
                  fuse_rden         <= 1'b1;
                  fuse_read_data_in <= way_q[r][0];
                  @(negedge rclk);
                  check_val("model fuse bit", LINE_W'(fuse_m[CHAIN_W-1]),
                            LINE_W'(exp_q[r][int'(set_q[r])-1-i]));
                  check_val("fuse_data_out", LINE_W'(fuse_data_out),
                            LINE_W'(fuse_m[CHAIN_W-1]));
                  fuse_m = {fuse_m[CHAIN_W-2:0], way_q[r][0]};
               end
               @(posedge rclk);
               fuse_rden <= 1'b0;
            end
            default: begin
               $display("unknown operation in the stimulus file");
               $display("test failed");
               $fatal(1);
            end
         endcase
         repeat ($urandom_range(2)) @(posedge rclk);   // idle gap
      end

      $display("test passed");
      $finish;
   end

endmodule

// File: verif/l2d_stim.txt
# op set way wen data exp, all hex; ops W R D(disabled write) B(read+write pair) F S
# F: set=register id, data=9 bit pattern; S: set=shift count, way=serial in, exp=bits out
W 05 1 F 0123456789ABCDEF0123456789ABCDEF0123456 0
R 05 1 0 0 0123456789ABCDEF0123456789ABCDEF0123456
W 0A 1 F 0 0
W 0A 1 5 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0
R 0A 1 0 0 0000000001FFFFFFFFFC0000000007FFFFFFFFF
W 10 1 F FEDCBA9876543210FEDCBA9876543210FEDCBA9 0
W 10 2 F 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5 0
W 50 1 F 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3 0
W 50 2 F 966996699669966996699669966996699669966 0
R 10 1 0 0 FEDCBA9876543210FEDCBA9876543210FEDCBA9
R 10 2 0 0 5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5
R 50 1 0 0 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3
R 50 2 0 0 966996699669966996699669966996699669966
D 10 1 F 966996699669966996699669966996699669966 0
R 10 1 0 0 FEDCBA9876543210FEDCBA9876543210FEDCBA9
B 50 1 F 0123456789ABCDEF0123456789ABCDEF0123456 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3
R 50 1 0 0 3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3C3
F 0 0 0 1A5 0
F 1 0 0 0F3 0
F 4 0 0 155 0
F 2 0 0 0AA 0
F 3 0 0 1C7 0
F 5 0 0 038 0
S 6C 1 0 0 D2BCEAAAAE38E34AF3AAAAB8E38
